// File: verilog/htb_pkg.sv
// Huffman tree builder shared sizes and types.
// Work-table entries, merge records, configuration and FSM states.
package htb_pkg;

  localparam int num_syms  = 16;
  localparam int sym_w     = 4;
  localparam int freq_w    = 12;
  localparam int len_w     = 4;
  localparam int rebuild_w = 3;

  // one leaf or internal node of the work table.
  typedef struct packed {
    logic              is_node;
    logic [sym_w-1:0]  idx;      // slot for a leaf, node id for a node.
    logic [freq_w-1:0] freq;
  } htb_entry_t;

  // one build step, the two lightest entries and the node they form.
  typedef struct packed {
    logic             valid;
    htb_entry_t       a;
    htb_entry_t       b;
    logic [sym_w-1:0] node;
  } htb_merge_t;

  typedef struct packed {
    logic [len_w-1:0]     max_code_length;
    logic [rebuild_w-1:0] max_rebuilds;
  } htb_cfg_t;

  typedef enum logic [2:0] {
    idle,
    build,
    drain,
    check,
    rebuild
  } htb_state_e;

endpackage

// File: verilog/htb_rebuild_counter.sv
// Rebuild counter for the current load, with its limit compare.
module htb_rebuild_counter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            count_clr,
  input  logic                            count_inc,
  input  logic [htb_pkg::rebuild_w-1:0]   max_rebuilds,
  output logic [htb_pkg::rebuild_w-1:0]   count,
  output logic                            at_limit
);

  logic [htb_pkg::rebuild_w-1:0] count_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q <= '0;
    end
    else if (count_clr)
    begin
      count_q <= '0;
    end
    else if (count_inc && (count_q != '1))
    begin
      count_q <= count_q + 1'b1;  // saturates at full scale.
    end
  end

  // the clear shows up at once so the first table load sees undivided data.
  assign count = count_clr ? '0 : count_q;

  assign at_limit = (count == max_rebuilds);

endmodule

// File: verilog/htb_freq_store.sv
// Frequency store for the loaded list.
// Gives the work table each frequency divided by two to the rebuild count.
module htb_freq_store (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          load,
  input  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]   syms,
  input  logic [htb_pkg::sym_w:0]                       first_used,
  input  logic [htb_pkg::rebuild_w-1:0]                 count,
  output htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]   divided,
  output logic [htb_pkg::sym_w:0]                       first_stored
);

  logic [htb_pkg::num_syms-1:0][htb_pkg::freq_w-1:0] stored;
  logic [htb_pkg::num_syms-1:0][htb_pkg::freq_w-1:0] shifted;

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      for (int i = 0; i < htb_pkg::num_syms; i++)
      begin
        stored[i] <= syms[i].freq;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      first_stored <= '0;
    else if (load)
      first_stored <= first_used;
  end

  always_comb
  begin
    for (int i = 0; i < htb_pkg::num_syms; i++)
    begin
      shifted[i]         = stored[i] >> count;
      divided[i].is_node = 1'b0;
      divided[i].idx     = htb_pkg::sym_w'(i);  // leaves are named by slot.
      // floor at one keeps used symbols in the tree and the order intact.
      if ((stored[i] != '0) && (shifted[i] == '0))
        divided[i].freq = htb_pkg::freq_w'(1);
      else
        divided[i].freq = shifted[i];
    end
  end

endmodule

// File: verilog/htb_work_table.sv
// Sorted work table of the tree builder.
// Merges the two lightest entries per enabled cycle and issues a merge record.
module htb_work_table (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start_build,
  input  logic                                          build_en,
  input  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]   divided,
  input  logic [htb_pkg::sym_w:0]                       first_stored,
  output htb_pkg::htb_merge_t                           merge,
  output logic                                          last_merge
);

  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0] tbl;
  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0] tbl_nxt;
  htb_pkg::htb_entry_t                         lo;
  htb_pkg::htb_entry_t                         hi;
  htb_pkg::htb_entry_t                         node;
  logic [htb_pkg::sym_w-1:0]                   ptr;
  logic [htb_pkg::sym_w-1:0]                   ptr_nxt;
  logic [htb_pkg::freq_w:0]                    sum_full;
  logic [htb_pkg::num_syms:0]                  le_sum;  // entry weight <= new node, top bit 0.
  logic                                        can_merge;

  assign ptr_nxt   = ptr + 1'b1;
  assign can_merge = (ptr < htb_pkg::num_syms - 1);
  assign lo        = tbl[ptr];
  assign hi        = tbl[ptr_nxt];  // wraps only when no merge is left.
  assign sum_full  = lo.freq + hi.freq;

  assign node.is_node = 1'b1;
  assign node.idx     = ptr_nxt;
  assign node.freq    = sum_full[htb_pkg::freq_w] ? '1 : sum_full[htb_pkg::freq_w-1:0];

  assign last_merge = build_en && (ptr >= htb_pkg::num_syms - 2);

  always_comb
  begin
    le_sum = '0;
    for (int j = 0; j < htb_pkg::num_syms; j++)
    begin
      le_sum[j] = (tbl[j].freq <= node.freq);
    end
    tbl_nxt = tbl;
    // remaining entries not heavier than the node move down one slot.
    for (int j = 0; j < htb_pkg::num_syms - 1; j++)
    begin
      if ((j > ptr) && le_sum[j+1])
        tbl_nxt[j] = tbl[j+1];
    end
    // the node lands after the last of them, ties stay ahead of it.
    for (int j = 1; j < htb_pkg::num_syms; j++)
    begin
      if ((j > ptr) && ((j == ptr + 1) || le_sum[j]) && !le_sum[j+1])
        tbl_nxt[j] = node;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start_build)
      tbl <= divided;
    else if (build_en && can_merge)
      tbl <= tbl_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ptr   <= '0;
      merge <= '0;
    end
    else if (start_build)
    begin
      ptr         <= first_stored[htb_pkg::sym_w-1:0];
      merge.valid <= 1'b0;
    end
    else if (build_en && can_merge)
    begin
      ptr        <= ptr_nxt;
      merge.valid <= 1'b1;
      merge.a    <= lo;
      merge.b    <= hi;
      merge.node <= ptr_nxt;
    end
    else
    begin
      merge.valid <= 1'b0;
    end
  end

endmodule

// File: verilog/htb_depth_table.sv
// Per-symbol depth table.
// Follows which node holds each symbol and counts its depth, flags overlong codes.
module htb_depth_table (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             start_build,
  input  htb_pkg::htb_merge_t                              merge,
  input  logic [htb_pkg::len_w-1:0]                        max_code_length,
  output logic [htb_pkg::num_syms-1:0][htb_pkg::len_w-1:0] depth,
  output logic                                             over_length
);

  logic [htb_pkg::num_syms-1:0]                      in_tree;
  logic [htb_pkg::num_syms-1:0]                      in_tree_nxt;
  logic [htb_pkg::num_syms-1:0][htb_pkg::sym_w-1:0]  owner;      // node now holding the symbol.
  logic [htb_pkg::num_syms-1:0][htb_pkg::sym_w-1:0]  owner_nxt;
  logic [htb_pkg::num_syms-1:0][htb_pkg::len_w-1:0]  depth_nxt;
  htb_pkg::htb_entry_t [1:0]                         pair;
  logic                                              over_nxt;
  logic                                              hit;

  assign pair[0] = merge.a;
  assign pair[1] = merge.b;

  always_comb
  begin
    in_tree_nxt = in_tree;
    owner_nxt   = owner;
    depth_nxt   = depth;
    over_nxt    = 1'b0;
    for (int s = 0; s < htb_pkg::num_syms; s++)
    begin
      hit = 1'b0;
      for (int e = 0; e < 2; e++)
      begin
        if (!pair[e].is_node && (pair[e].idx == s))
          hit = 1'b1;  // leaf joins its first node.
        if (pair[e].is_node && in_tree[s] && (owner[s] == pair[e].idx))
          hit = 1'b1;
      end
      if (merge.valid && hit)
      begin
        in_tree_nxt[s] = 1'b1;
        owner_nxt[s]   = merge.node;
        depth_nxt[s]   = depth[s] + 1'b1;
      end
      if (depth_nxt[s] > max_code_length)
        over_nxt = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    owner <= owner_nxt;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      in_tree     <= '0;
      depth       <= '0;
      over_length <= 1'b0;
    end
    else if (start_build)
    begin
      in_tree     <= '0;
      depth       <= '0;
      over_length <= 1'b0;
    end
    else
    begin
      in_tree     <= in_tree_nxt;
      depth       <= depth_nxt;
      over_length <= over_nxt;  // ready in the cycle after the last depth update.
    end
  end

endmodule

// File: verilog/htb_fsm.sv
// Tree builder control FSM.
// Sequences load, merge, drain, length check and rebuild, and holds the result flags.
module htb_fsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    load,
  input  logic [htb_pkg::sym_w:0] first_used,
  input  logic                    last_merge,
  input  logic                    over_length,
  input  logic                    at_limit,
  output logic                    busy,
  output logic                    done,
  output logic                    start_build,
  output logic                    build_en,
  output logic                    count_clr,
  output logic                    count_inc,
  output logic                    build_error,
  output logic                    zero_symbols
);

  htb_pkg::htb_state_e state;
  logic                zero_pend;  // current load had no used symbol.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state        <= htb_pkg::idle;
      busy         <= 1'b0;
      done         <= 1'b0;
      start_build  <= 1'b0;
      build_en     <= 1'b0;
      count_clr    <= 1'b0;
      count_inc    <= 1'b0;
      build_error  <= 1'b0;
      zero_symbols <= 1'b0;
      zero_pend    <= 1'b0;
    end
    else
    begin
      done        <= 1'b0;
      start_build <= 1'b0;
      count_clr   <= 1'b0;
      count_inc   <= 1'b0;
      case (state)
        htb_pkg::idle:
        begin
          if (load)
          begin
            busy        <= 1'b1;
            start_build <= 1'b1;  // also clears the depths of an empty list.
            count_clr   <= 1'b1;
            zero_pend   <= (first_used == htb_pkg::num_syms);
            state       <= (first_used == htb_pkg::num_syms) ? htb_pkg::check : htb_pkg::build;
          end
        end
        htb_pkg::build:
        begin
          if (start_build)
          begin
            build_en <= 1'b1;  // table is loaded, merging starts next cycle.
          end
          if (last_merge)
          begin
            build_en <= 1'b0;
            state    <= htb_pkg::drain;
          end
        end
        htb_pkg::drain:
        begin
          state <= htb_pkg::check;  // last merge record lands in the depth table.
        end
        htb_pkg::check:
        begin
          if (zero_pend || !over_length || at_limit)
          begin
            done         <= 1'b1;
            busy         <= 1'b0;
            build_error  <= over_length & ~zero_pend;
            zero_symbols <= zero_pend;
            state        <= htb_pkg::idle;
          end
          else
          begin
            count_inc <= 1'b1;
            state     <= htb_pkg::rebuild;
          end
        end
        htb_pkg::rebuild:
        begin
          start_build <= 1'b1;  // count has moved, reload from the divided list.
          state       <= htb_pkg::build;
        end
        default:
        begin
          state <= htb_pkg::idle;
        end
      endcase
    end
  end

endmodule

// File: verilog/htb_top.sv
// Huffman code-length tree builder.
// Turns a sorted frequency list into per-symbol code depths, rebuilding on overflow.
module htb_top (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          load,
  input  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]   syms,
  input  logic [htb_pkg::sym_w:0]                       first_used,
  input  htb_pkg::htb_cfg_t                             cfg,
  output logic                                          busy,
  output logic                                          done,
  output logic [htb_pkg::num_syms-1:0][htb_pkg::len_w-1:0] depth,
  output logic                                          build_error,
  output logic                                          zero_symbols,
  output logic [htb_pkg::rebuild_w-1:0]                 rebuild_count
);

  logic                                          start_build;
  logic                                          build_en;
  logic                                          count_clr;
  logic                                          count_inc;
  logic                                          at_limit;
  logic                                          last_merge;
  logic                                          over_length;
  logic                                          load_idle;
  logic [htb_pkg::sym_w:0]                       first_stored;
  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]   divided;
  htb_pkg::htb_merge_t                           merge;

  assign load_idle = load & ~busy;  // a load while busy must not touch the stored list.

  htb_fsm i_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load),
    .first_used   (first_used),
    .last_merge   (last_merge),
    .over_length  (over_length),
    .at_limit     (at_limit),
    .busy         (busy),
    .done         (done),
    .start_build  (start_build),
    .build_en     (build_en),
    .count_clr    (count_clr),
    .count_inc    (count_inc),
    .build_error  (build_error),
    .zero_symbols (zero_symbols)
  );

  htb_rebuild_counter i_rebuild_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .count_clr    (count_clr),
    .count_inc    (count_inc),
    .max_rebuilds (cfg.max_rebuilds),
    .count        (rebuild_count),
    .at_limit     (at_limit)
  );

  htb_freq_store i_freq_store (
    .clk          (clk),
    .rst_n        (rst_n),
    .load         (load_idle),
    .syms         (syms),
    .first_used   (first_used),
    .count        (rebuild_count),
    .divided      (divided),
    .first_stored (first_stored)
  );

  htb_work_table i_work_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_build  (start_build),
    .build_en     (build_en),
    .divided      (divided),
    .first_stored (first_stored),
    .merge        (merge),
    .last_merge   (last_merge)
  );

  htb_depth_table i_depth_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_build     (start_build),
    .merge           (merge),
    .max_code_length (cfg.max_code_length),
    .depth           (depth),
    .over_length     (over_length)
  );

endmodule

// File: dv/htb_sva.sv
// FSM strobe checks for the tree builder, bound into htb_fsm.
module htb_sva (
  input logic clk,
  input logic rst_n,
  input logic done,
  input logic busy,
  input logic start_build,
  input logic build_en
);

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else $error("busy was high together with done");

  load_apart_from_merge: assert property (@(posedge clk) disable iff (!rst_n)
    !(start_build && build_en))
    else $error("start_build came while build_en was high");

endmodule

bind htb_fsm htb_sva i_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .done        (done),
  .busy        (busy),
  .start_build (start_build),
  .build_en    (build_en)
);

// File: dv/htb_checker.sv
// Result checker for the tree builder.
// Captures each accepted load, models the merge and rebuild rules, compares at done.
module htb_checker (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             load,
  input  htb_pkg::htb_entry_t [htb_pkg::num_syms-1:0]      syms,
  input  logic [htb_pkg::sym_w:0]                          first_used,
  input  htb_pkg::htb_cfg_t                                cfg,
  input  logic                                             busy,
  input  logic                                             done,
  input  logic [htb_pkg::num_syms-1:0][htb_pkg::len_w-1:0] depth,
  input  logic                                             build_error,
  input  logic                                             zero_symbols,
  input  logic [htb_pkg::rebuild_w-1:0]                    rebuild_count,
  input  int                                               test_id,
  output int                                               results,
  output int                                               mismatches,
  output int                                               failures
);

  localparam int n = htb_pkg::num_syms;

  int             cap_freq [n];
  int             cap_first;
  int             cap_max_len;
  int             cap_max_reb;
  int             load_cycle;
  int             cycle;
  bit             pending;
  int             tf [n];     // model table weights.
  logic [n-1:0]   tm [n];     // leaves beneath each model entry.
  int             md [n];
  bit             over;
  bit             exp_err;
  int             exp_count;

  function automatic string test_name(input int id);
    case (id)
      1: return "short_random";
      2: return "skewed_rebuild";
      3: return "rebuild_limit";
      4: return "all_zero";
      5: return "single_symbol";
      6: return "equal_freqs";
      7: return "load_while_busy";
      default: return "unknown";
    endcase
  endfunction

  // one build on the list divided by 2**k.
  task automatic build_tree(input int k);
    int           p;
    int           nf;
    int           c;
    logic [n-1:0] nm;
    for (int j = 0; j < n; j++)
    begin
      tf[j] = cap_freq[j] >> k;
      if (cap_freq[j] != 0 && tf[j] == 0)
        tf[j] = 1;
      tm[j] = '0;
      tm[j][j] = 1'b1;
      md[j] = 0;
    end
    p = cap_first;
    while (p < n - 1)
    begin
      nf = tf[p] + tf[p+1];
      nf = (nf > 4095) ? 4095 : nf;
      nm = tm[p] | tm[p+1];
      for (int s = 0; s < n; s++)
        if (nm[s])
          md[s]++;
      c = 0;
      for (int j = p + 2; j < n; j++)
        if (tf[j] <= nf)
          c++;  // lighter or equal entries stay ahead of the node.
      for (int j = p + 1; j < p + 1 + c; j++)
      begin
        tf[j] = tf[j+1];
        tm[j] = tm[j+1];
      end
      tf[p+1+c] = nf;
      tm[p+1+c] = nm;
      p++;
    end
    over = 1'b0;
    for (int s = 0; s < n; s++)
      if (md[s] > cap_max_len)
        over = 1'b1;
  endtask

  task automatic compare_result;
    string name;
    int    k;
    int    kraft;
    name = test_name(test_id);
    k = 0;
    build_tree(k);
    while (over && k != cap_max_reb)
    begin
      k++;
      build_tree(k);
    end
    exp_err = over;
    exp_count = k;
    for (int s = 0; s < n; s++)
      if (int'(depth[s]) != md[s])
      begin
        $display("Mismatch %s depth[%0d] expected %0d actual %0d", name, s, md[s], depth[s]);
        mismatches++;
      end
    if (build_error !== exp_err)
    begin
      $display("Mismatch %s build_error expected %0b actual %0b", name, exp_err, build_error);
      mismatches++;
    end
    if (zero_symbols !== (cap_first == n))
    begin
      $display("Mismatch %s zero_symbols expected %0b actual %0b", name, cap_first == n,
               zero_symbols);
      mismatches++;
    end
    if (int'(rebuild_count) != exp_count)
    begin
      $display("Mismatch %s rebuild_count expected %0d actual %0d", name, exp_count,
               rebuild_count);
      mismatches++;
    end
    if (cap_first == n && cycle - load_cycle != 2)
    begin
      $display("Mismatch %s load to done cycles expected 2 actual %0d", name, cycle - load_cycle);
      mismatches++;
    end
    kraft = 0;
    for (int s = cap_first; s < n; s++)
      kraft += 1 << (15 - int'(depth[s]));
    if (cap_first < n && kraft != (1 << 15))
    begin
      $display("%s: the used symbols' depths do not form a full code tree", name);
      failures++;
    end
    for (int s = 0; s < n; s++)
      if (!build_error && int'(depth[s]) > cap_max_len)
      begin
        $display("%s: depth of slot %0d is over the maximum without a build error", name, s);
        failures++;
      end
    results++;
  endtask

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      pending = 1'b0;
      cycle = 0;
      results = 0;
      mismatches = 0;
      failures = 0;
    end
    else
    begin
      cycle++;
      if (!done && (busy !== pending))
      begin
        $display("%s: busy did not stay high from the load until done", test_name(test_id));
        failures++;
      end
      if (done && !pending)
      begin
        $display("%s: done came without an accepted load", test_name(test_id));
        failures++;
      end
      else if (done)
      begin
        compare_result();
        pending = 1'b0;
      end
      if (load && !busy)
      begin
        for (int j = 0; j < n; j++)
          cap_freq[j] = int'(syms[j].freq);
        cap_first = int'(first_used);
        cap_max_len = int'(cfg.max_code_length);
        cap_max_reb = int'(cfg.max_rebuilds);
        load_cycle = cycle;
        pending = 1'b1;
      end
    end
  end

endmodule

// File: dv/htb_tb.sv
// Testbench for the Huffman code-length tree builder.
// Drives sorted frequency lists drawn from an LFSR; htb_checker judges the results.
module htb_tb;

  localparam int n          = htb_pkg::num_syms;
  localparam int done_limit = 2000;  // well above eight full builds.

  logic                                             clk;
  logic                                             rst_n;
  logic                                             load;
  htb_pkg::htb_entry_t [n-1:0]                      syms;
  logic [htb_pkg::sym_w:0]                          first_used;
  htb_pkg::htb_cfg_t                                cfg;
  logic                                             busy;
  logic                                             done;
  logic [n-1:0][htb_pkg::len_w-1:0]                 depth;
  logic                                             build_error;
  logic                                             zero_symbols;
  logic [htb_pkg::rebuild_w-1:0]                    rebuild_count;
  logic [31:0]                                      lfsr;
  int                                               freqs [n];
  int                                               reps [1:7] = '{20, 12, 6, 2, 4, 8, 3};
  int                                               test_id;
  int                                               tests_run;
  int                                               tb_errors;
  int                                               results;
  int                                               mismatches;
  int                                               failures;
  bit                                               stop;

  always #20 clk = ~clk;

  htb_top i_dut (
    .clk (clk), .rst_n (rst_n), .load (load), .syms (syms), .first_used (first_used),
    .cfg (cfg), .busy (busy), .done (done), .depth (depth), .build_error (build_error),
    .zero_symbols (zero_symbols), .rebuild_count (rebuild_count)
  );

  htb_checker i_checker (
    .clk (clk), .rst_n (rst_n), .load (load), .syms (syms), .first_used (first_used),
    .cfg (cfg), .busy (busy), .done (done), .depth (depth), .build_error (build_error),
    .zero_symbols (zero_symbols), .rebuild_count (rebuild_count), .test_id (test_id),
    .results (results), .mismatches (mismatches), .failures (failures)
  );

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int bits, output int unsigned v);
    v = 0;
    for (int i = 0; i < bits; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // sorts freqs[0..cnt-1] and puts them in the top slots, zero slots first.
  task automatic place_list(input int cnt);
    int t;
    for (int i = 0; i < cnt; i++)
      for (int j = 0; j < cnt - 1 - i; j++)
        if (freqs[j] > freqs[j+1])
        begin
          t = freqs[j];
          freqs[j] = freqs[j+1];
          freqs[j+1] = t;
        end
    first_used = (htb_pkg::sym_w + 1)'(n - cnt);
    for (int i = 0; i < n; i++)
    begin
      syms[i].is_node = 1'b0;
      syms[i].idx = htb_pkg::sym_w'(i);
      if (i < n - cnt)
        syms[i].freq = '0;
      else
        syms[i].freq = htb_pkg::freq_w'(freqs[i - (n - cnt)]);
    end
  endtask

  task automatic make_list(input int cnt, input int bits);
    int unsigned v;
    for (int i = 0; i < cnt; i++)
    begin
      draw(bits, v);
      freqs[i] = (v == 0) ? 1 : int'(v);
    end
    place_list(cnt);
  endtask

  // fibonacci-like weights, the most skewed tree for their size.
  task automatic make_series(input int cnt, input int f0, input int f1);
    freqs[0] = f0;
    freqs[1] = f1;
    for (int i = 2; i < cnt; i++)
      freqs[i] = freqs[i-1] + freqs[i-2];
    place_list(cnt);
  endtask

  task automatic wait_done;
    int cyc;
    cyc = 0;
    while (!done && cyc < done_limit)
    begin
      @(negedge clk);
      cyc++;
    end
    if (!done)
    begin
      $display("timeout in test %0d, done never came after the load", test_id);
      tb_errors++;
      stop = 1'b1;
    end
    tests_run++;
  endtask

  task automatic run_test(input int id);
    int unsigned v;
    int unsigned w;
    @(negedge clk);
    test_id = id;
    cfg.max_code_length = 4'd15;
    cfg.max_rebuilds = 3'd3;
    draw(4, v);
    case (id)
      1:
      begin
        make_list(int'(v[2:0]) + 1, 8);
        cfg.max_rebuilds = v[3] ? 3'd0 : 3'd3;
      end
      2:
      begin
        draw(2, w);
        make_series(5 + int'(v[1:0]), 1 + int'(w[0]), 1 + int'(w[0]) + int'(w[1]));
        cfg.max_code_length = 4'(4 + v[3:2] % 3);
        cfg.max_rebuilds = 3'd7;  // weights under 64 fit by the sixth rebuild.
      end
      3:
      begin
        make_series(12, 1, 1);
        cfg.max_code_length = 4'(4 + v[0]);
        cfg.max_rebuilds = 3'(v[3:1] % 3);
      end
      4: place_list(0);
      5: make_list(1, 12);
      6: make_list((v < 2) ? 16 : int'(v) + 1, 2);
      default:
      begin
        make_series(6 + int'(v[1:0]), 1, 1);
        cfg.max_code_length = 4'd4;  // the rebuild reads the stored list again.
      end
    endcase
    load = 1'b1;
    @(negedge clk);
    load = 1'b0;
    if (id == 7)
    begin
      @(negedge clk);
      make_list(16, 8);  // must be ignored, the build is running.
      load = 1'b1;
      @(negedge clk);
      load = 1'b0;
    end
    wait_done();
  endtask

  initial
  begin
    clk = 1'b0;
    rst_n = 1'b0;
    load = 1'b0;
    syms = '0;
    first_used = '0;
    cfg = '0;
    lfsr = 32'h04e99bec;
    test_id = 0;
    tests_run = 0;
    tb_errors = 0;
    stop = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    for (int id = 1; id <= 7; id++)
      for (int i = 0; i < reps[id] && !stop; i++)
        run_test(id);
    repeat (4) @(negedge clk);
    if (!stop && results != tests_run)
    begin
      $display("only %0d of %0d results were checked", results, tests_run);
      tb_errors++;
    end
    $display("checked %0d results: %0d mismatches, %0d checker errors, %0d testbench errors",
             results, mismatches, failures, tb_errors);
    if (mismatches + failures + tb_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// File: compile.f
verilog/htb_pkg.sv
verilog/htb_rebuild_counter.sv
verilog/htb_freq_store.sv
verilog/htb_work_table.sv
verilog/htb_depth_table.sv
verilog/htb_fsm.sv
verilog/htb_top.sv
dv/htb_sva.sv
dv/htb_checker.sv
dv/htb_tb.sv
